/* Bender.yml */
package:
  name: exec_commit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/exec_pkg.sv
      - hdl/elastic_buffer.sv
      - hdl/alu_block.sv
      - hdl/gather_unit.sv
      - hdl/exec_commit_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/exec_commit_properties.sv
      - sim/exec_commit_tb.sv

/* hdl/alu_block.sv */
// One execute block: per-lane integer ALU on a lane group
// The result leaves through a skid buffer as a partial commit
`include "exec_params.svh"

module alu_block (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  exec_pkg::exec_req_t    req,
    output logic                   part_valid,
    input  logic                   part_ready,
    output exec_pkg::commit_part_t part
);
    import exec_pkg::*;

    commit_part_t result;

    // Tags and mask pass straight through to the partial commit
    always_comb begin
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;

        result.uuid  = req.uuid;
        result.wid   = req.wid;
        result.tmask = req.tmask;
        result.pid   = req.pid;
        result.rd    = req.rd;
        result.wb    = req.wb;
        result.eop   = req.eop;

        for (int j = 0; j < `NUM_LANES; j++) begin
            a = req.rs1[j];
            b = req.rs2[j];
            case (req.op)
                ADD:     result.data[j] = a + b;
                SUB:     result.data[j] = a - b;
                AND:     result.data[j] = a & b;
                OR:      result.data[j] = a | b;
                XOR:     result.data[j] = a ^ b;
                // Unsigned compare, zero extended to a full word
                SLTU:    result.data[j] = `XLEN'(a < b);
                default: result.data[j] = '0;
            endcase
        end
    end

    // The buffer's registered ready is the block's request ready, so a
    // stalled commit path holds requests back without extra logic
    elastic_buffer #(
        .payload_t (commit_part_t)
    ) i_out_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (result),
        .out_valid (part_valid),
        .out_ready (part_ready),
        .out_data  (part)
    );

endmodule

/* hdl/elastic_buffer.sv */
// Two-entry skid buffer with registered valid, ready and data
// Used as the pipeline register on every valid/ready link
module elastic_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     skid_valid;
    logic     skid_valid_next;
    payload_t skid_data;
    logic     main_load;
    logic     in_fire;

    // The main register may take a new beat when it is empty or being drained
    assign main_load = out_ready || !out_valid;
    assign in_fire   = in_valid && in_ready;

    always_comb begin
        skid_valid_next = skid_valid;
        if (main_load) begin
            // Any held beat moves into the main register
            skid_valid_next = 1'b0;
        end else if (in_fire) begin
            // Output is stalled, so the incoming beat parks in the skid slot
            skid_valid_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            skid_valid <= skid_valid_next;
            in_ready   <= !skid_valid_next;
            if (main_load) begin
                out_valid <= skid_valid || in_fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (!main_load && in_fire) begin
            skid_data <= in_data;
        end
    end

endmodule

/* hdl/exec_commit_top.sv */
// Execute and commit path: ALU blocks feeding the gather unit
// Requests enter per block, full-width commits leave per issue slot
`include "exec_params.svh"

module exec_commit_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`BLOCK_SIZE-1:0]                  req_valid,
    output logic [`BLOCK_SIZE-1:0]                  req_ready,
    input  exec_pkg::exec_req_t [`BLOCK_SIZE-1:0]   req,
    output logic [`ISSUE_WIDTH-1:0]                 commit_valid,
    input  logic [`ISSUE_WIDTH-1:0]                 commit_ready,
    output exec_pkg::commit_t [`ISSUE_WIDTH-1:0]    commit
);
    import exec_pkg::*;

    logic [`BLOCK_SIZE-1:0]         part_valid;
    logic [`BLOCK_SIZE-1:0]         part_ready;
    commit_part_t [`BLOCK_SIZE-1:0] part;

    for (genvar b = 0; b < `BLOCK_SIZE; b++) begin : g_block
        alu_block i_alu_block (
            .clk        (clk),
            .rst_n      (rst_n),
            .req_valid  (req_valid[b]),
            .req_ready  (req_ready[b]),
            .req        (req[b]),
            .part_valid (part_valid[b]),
            .part_ready (part_ready[b]),
            .part       (part[b])
        );
    end

    gather_unit i_gather_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .part_valid   (part_valid),
        .part_ready   (part_ready),
        .part         (part),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

endmodule

/* hdl/exec_params.svh */
// Sizing macros for the execute and commit path
// Include before any file that uses the shared types or widths
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Warp and lane-group geometry
`define NUM_THREADS 4
`define NUM_LANES   2

// A warp is covered in NUM_PARTS passes of one lane group each
`define NUM_PARTS   (`NUM_THREADS / `NUM_LANES)
`define PID_W       $clog2(`NUM_PARTS)

// Execute blocks and issue slots
`define BLOCK_SIZE  2
`define ISSUE_WIDTH 4
`define ISSUE_IDX_W $clog2(`ISSUE_WIDTH)

// Warp ids
`define NUM_WARPS   8
`define NW_W        $clog2(`NUM_WARPS)

// Datapath and tag widths
`define XLEN        32
`define NR_BITS     5
`define UUID_W      16

`endif

/* hdl/exec_pkg.sv */
// Opcode and payload types shared by the execute blocks and the gather unit
`include "exec_params.svh"

package exec_pkg;

    // Integer ALU operations where SLTU compares unsigned and gives 1 or 0
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        SLTU = 3'd5
    } alu_op_e;

    // One pass of a warp instruction on a single lane group
    typedef struct packed {
        logic [`UUID_W-1:0]                   uuid;
        logic [`NW_W-1:0]                     wid;
        logic [`NUM_LANES-1:0]                tmask;
        logic [`PID_W-1:0]                    pid;
        alu_op_e                              op;
        logic [`NR_BITS-1:0]                  rd;
        logic                                 wb;
        logic                                 eop;
        logic [`NUM_LANES-1:0][`XLEN-1:0]     rs1;
        logic [`NUM_LANES-1:0][`XLEN-1:0]     rs2;
    } exec_req_t;

    // Lane-group result, still tagged with the pass index
    typedef struct packed {
        logic [`UUID_W-1:0]                   uuid;
        logic [`NW_W-1:0]                     wid;
        logic [`NUM_LANES-1:0]                tmask;
        logic [`PID_W-1:0]                    pid;
        logic [`NR_BITS-1:0]                  rd;
        logic                                 wb;
        logic                                 eop;
        logic [`NUM_LANES-1:0][`XLEN-1:0]     data;
    } commit_part_t;

    // Result placed at full warp width for the commit port
    typedef struct packed {
        logic [`UUID_W-1:0]                   uuid;
        logic [`NW_W-1:0]                     wid;
        logic [`NUM_THREADS-1:0]              tmask;
        logic [`NR_BITS-1:0]                  rd;
        logic                                 wb;
        logic                                 eop;
        logic [`NUM_THREADS-1:0][`XLEN-1:0]   data;
    } commit_t;

endpackage

/* hdl/gather_unit.sv */
// Steers partial commits from the execute blocks to issue-slot ports
// Each slot is buffered, then its lane group is placed in the warp by pid
`include "exec_params.svh"

module gather_unit (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic [`BLOCK_SIZE-1:0]                      part_valid,
    output logic [`BLOCK_SIZE-1:0]                      part_ready,
    input  exec_pkg::commit_part_t [`BLOCK_SIZE-1:0]    part,
    output logic [`ISSUE_WIDTH-1:0]                     commit_valid,
    input  logic [`ISSUE_WIDTH-1:0]                     commit_ready,
    output exec_pkg::commit_t [`ISSUE_WIDTH-1:0]        commit
);
    import exec_pkg::*;

    localparam int BLK_W = $clog2(`BLOCK_SIZE);

    logic [`BLOCK_SIZE-1:0][`ISSUE_IDX_W-1:0] slot;
    logic [`ISSUE_WIDTH-1:0]                  buf_in_valid;
    logic [`ISSUE_WIDTH-1:0]                  buf_in_ready;
    commit_part_t [`ISSUE_WIDTH-1:0]          buf_in_data;
    commit_part_t [`ISSUE_WIDTH-1:0]          buf_out_data;

    // Slot index is the block number in the low bits, with the wid bits
    // above the block-select bits on top
    for (genvar b = 0; b < `BLOCK_SIZE; b++) begin : g_slot
        assign slot[b] = {part[b].wid[BLK_W +: (`ISSUE_IDX_W - BLK_W)], BLK_W'(b)};
        assign part_ready[b] = buf_in_ready[slot[b]];
    end

    // Dispatch keeps blocks on disjoint slots, so no two blocks collide here
    always_comb begin
        buf_in_valid = '0;
        buf_in_data  = '0;
        for (int b = 0; b < `BLOCK_SIZE; b++) begin
            buf_in_valid[slot[b]] = part_valid[b];
            buf_in_data[slot[b]]  = part[b];
        end
    end

    for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : g_buf
        elastic_buffer #(
            .payload_t (commit_part_t)
        ) i_slot_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (buf_in_valid[s]),
            .in_ready  (buf_in_ready[s]),
            .in_data   (buf_in_data[s]),
            .out_valid (commit_valid[s]),
            .out_ready (commit_ready[s]),
            .out_data  (buf_out_data[s])
        );
    end

    // Widen to warp width: lane j of pass pid lands on thread pid*NUM_LANES+j
    always_comb begin
        int base;

        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            commit[s].uuid  = buf_out_data[s].uuid;
            commit[s].wid   = buf_out_data[s].wid;
            commit[s].rd    = buf_out_data[s].rd;
            commit[s].wb    = buf_out_data[s].wb;
            commit[s].eop   = buf_out_data[s].eop;
            commit[s].tmask = '0;
            commit[s].data  = '0;
            base = int'(buf_out_data[s].pid) * `NUM_LANES;
            for (int j = 0; j < `NUM_LANES; j++) begin
                commit[s].tmask[base + j] = buf_out_data[s].tmask[j];
                commit[s].data[base + j]  = buf_out_data[s].data[j];
            end
        end
    end

endmodule

/* sim/exec_commit_properties.sv */
// Handshake and reset checks on the ports of the execute and commit path
// Bound to the top level and counts its own assertion failures
`include "exec_params.svh"

module exec_commit_properties (
    input logic                                    clk,
    input logic                                    rst_n,
    input logic [`BLOCK_SIZE-1:0]                  req_ready,
    input logic [`ISSUE_WIDTH-1:0]                 commit_valid,
    input logic [`ISSUE_WIDTH-1:0]                 commit_ready,
    input exec_pkg::commit_t [`ISSUE_WIDTH-1:0]    commit
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count;

    initial fail_count = 0;

    for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : g_slot
        // A stalled commit keeps its valid and its payload until taken
        a_commit_hold: assert property (@(posedge clk) disable iff (!rst_n)
            commit_valid[s] && !commit_ready[s] |=> commit_valid[s] && $stable(commit[s]))
        else begin
            fail_count++;
            $error("Commit on slot %0d dropped or changed while stalled", s);
        end

        a_commit_mask: assert property (@(posedge clk) disable iff (!rst_n)
            commit_valid[s] |-> commit[s].tmask != '0)
        else begin
            fail_count++;
            $error("Commit on slot %0d carries an empty thread mask", s);
        end
    end

    // Registers settle on the first reset edge, so the check starts one cycle in
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n ##1 !rst_n |-> commit_valid == '0 && req_ready == '0)
    else begin
        fail_count++;
        $error("Valid or ready output high during reset");
    end

endmodule

bind exec_commit_top exec_commit_properties i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_ready    (req_ready),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit       (commit)
);

/* sim/exec_commit_tb.sv */
// Testbench for the execute and commit path, driven from the trace file
// Requests go in per block and commits are checked per issue slot in order
`include "exec_params.svh"

module exec_commit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam int MAX_REC  = 64;
    localparam int MAX_TEST = 8;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [`BLOCK_SIZE-1:0]          req_valid;
    logic [`BLOCK_SIZE-1:0]          req_ready;
    exec_req_t [`BLOCK_SIZE-1:0]     req;
    logic [`ISSUE_WIDTH-1:0]         commit_valid;
    logic [`ISSUE_WIDTH-1:0]         commit_ready;
    commit_t [`ISSUE_WIDTH-1:0]      commit;

    string     test_name [MAX_TEST];
    bit        test_rand [MAX_TEST];
    int        test_hold [MAX_TEST];
    exec_req_t req_rec [MAX_REC];
    int        req_blk [MAX_REC];
    int        req_test [MAX_REC];
    commit_t   exp_rec [MAX_REC];
    int        exp_slot [MAX_REC];
    int        exp_test [MAX_REC];
    int        num_tests;
    int        num_reqs;
    int        num_exps;
    bit        loaded;

    commit_t     exp_q [`ISSUE_WIDTH][$];
    int          cur_test;
    bit          test_busy;
    int          errors;
    int          test_errors;
    int          checks;
    int          commits_seen;
    logic [31:0] rng_state;

    always #5 clk = ~clk;

    exec_commit_top i_exec_commit_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic alu_op_e op_from_name(input string name, output bit known);
        known = 1'b1;
        case (name)
            "ADD":   return ADD;
            "SUB":   return SUB;
            "AND":   return AND;
            "OR":    return OR;
            "XOR":   return XOR;
            "SLTU":  return SLTU;
            default: begin
                known = 1'b0;
                return ADD;
            end
        endcase
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            n += exp_q[s].size();
        end
        return n;
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        int          blk;
        int          rnd;
        int          hold;
        bit          known;
        string       kw;
        string       line;
        string       word;
        logic [31:0] f [11];

        fd = $fopen("sim/exec_commit_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/exec_commit_trace.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", kw) == 1) begin
                if (kw.substr(0, 0) == "#") begin
                    n = $fgets(line, fd);
                end else if (kw == "TEST") begin
                    n = $fscanf(fd, "%s %d %d", word, rnd, hold);
                    test_name[num_tests] = word;
                    test_rand[num_tests] = (rnd != 0);
                    test_hold[num_tests] = hold;
                    num_tests++;
                end else if (kw == "REQ") begin
                    n = $fscanf(fd, "%d %h %d %d %b %s %d %d %d %h %h %h %h", blk,
                                f[0], f[1], f[2], f[3], word, f[4], f[5], f[6],
                                f[7], f[8], f[9], f[10]);
                    req_rec[num_reqs] = '{uuid: f[0][`UUID_W-1:0], wid: f[1][`NW_W-1:0],
                                          pid: f[2][`PID_W-1:0], tmask: f[3][`NUM_LANES-1:0],
                                          op: op_from_name(word, known), rd: f[4][`NR_BITS-1:0],
                                          wb: f[5][0], eop: f[6][0],
                                          rs1: {f[8], f[7]}, rs2: {f[10], f[9]}};
                    if (n != 13 || !known || num_tests == 0) begin
                        $display("Malformed REQ record %0d in the trace file", num_reqs);
                        errors++;
                    end
                    req_blk[num_reqs]  = blk;
                    req_test[num_reqs] = num_tests - 1;
                    num_reqs++;
                end else if (kw == "EXP") begin
                    n = $fscanf(fd, "%d %h %d %b %d %d %d %h %h %h %h", blk,
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    exp_rec[num_exps] = '{uuid: f[0][`UUID_W-1:0], wid: f[1][`NW_W-1:0],
                                          tmask: f[2][`NUM_THREADS-1:0], rd: f[3][`NR_BITS-1:0],
                                          wb: f[4][0], eop: f[5][0],
                                          data: {f[9], f[8], f[7], f[6]}};
                    if (n != 11 || num_tests == 0) begin
                        $display("Malformed EXP record %0d in the trace file", num_exps);
                        errors++;
                    end
                    exp_slot[num_exps] = blk;
                    exp_test[num_exps] = num_tests - 1;
                    num_exps++;
                end else begin
                    $display("Unknown record type %s in the trace file", kw);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Holds each request until the block takes it, then moves on
    task automatic drive_block(input int b, input int t);
        for (int i = 0; i < num_reqs; i++) begin
            if (req_test[i] == t && req_blk[i] == b) begin
                req_valid[b] <= 1'b1;
                req[b]       <= req_rec[i];
                @(negedge clk);
                while (!req_ready[b]) @(negedge clk);
                @(posedge clk);
            end
        end
        req_valid[b] <= 1'b0;
    endtask

    // A held slot stalls only its own block, so the other block's slots must have drained
    task automatic check_other_block(input int t);
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            if (s % `BLOCK_SIZE != test_hold[t] % `BLOCK_SIZE) begin
                checks++;
                assert (exp_q[s].size() == 0)
                else begin
                    $display("Slot %0d in %s still waited for %0d commits while slot %0d was held",
                             s, test_name[t], exp_q[s].size(), test_hold[t]);
                    note_error();
                end
            end
        end
    endtask

    task automatic pace_ready(input int t);
        int                      hold_left;
        logic [`ISSUE_WIDTH-1:0] rdy;

        hold_left = (test_hold[t] >= 0) ? 20 : 0;
        while (test_busy) begin
            rng_state = xorshift32(rng_state);
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                // Ready about three cycles in four when stalls are on
                rdy[s] = test_rand[t] ? (rng_state[2*s +: 2] != 2'b00) : 1'b1;
            end
            if (hold_left > 0) begin
                rdy[test_hold[t]] = 1'b0;
                hold_left--;
                if (hold_left == 0) begin
                    check_other_block(t);
                end
            end
            commit_ready <= rdy;
            @(posedge clk);
        end
        commit_ready <= '1;
    endtask

    task automatic check_value(input int s, input string what, input logic [31:0] e,
                               input logic [31:0] a);
        checks++;
        assert (a === e)
        else begin
            $display("Mismatch in %s, slot %0d %s: expected %h, actual %h",
                     test_name[cur_test], s, what, e, a);
            note_error();
        end
    endtask

    task automatic check_commit(input int s, input commit_t got);
        commit_t exp;

        commits_seen++;
        assert (exp_q[s].size() != 0)
        else begin
            $display("Unexpected commit on slot %0d during %s with uuid %h",
                     s, test_name[cur_test], got.uuid);
            note_error();
        end
        if (exp_q[s].size() != 0) begin
            exp = exp_q[s].pop_front();
            check_value(s, "uuid", exp.uuid, got.uuid);
            check_value(s, "wid", exp.wid, got.wid);
            check_value(s, "tmask", exp.tmask, got.tmask);
            check_value(s, "rd", exp.rd, got.rd);
            check_value(s, "wb", exp.wb, got.wb);
            check_value(s, "eop", exp.eop, got.eop);
            for (int t = 0; t < `NUM_THREADS; t++) begin
                if (exp.tmask[t]) begin
                    check_value(s, $sformatf("data[%0d]", t), exp.data[t], got.data[t]);
                end
            end
        end
    endtask

    // Outputs are stable at the falling edge and a transfer seen there completes on the next rise
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (commit_valid == '0)
            else begin
                $display("A commit valid was high during reset: %b", commit_valid);
                note_error();
            end
        end else begin
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                if (commit_valid[s] && commit_ready[s]) begin
                    check_commit(s, commit[s]);
                end
            end
        end
    end

    task automatic run_test(input int t);
        int n_exp;

        n_exp       = 0;
        test_errors = 0;
        for (int i = 0; i < num_exps; i++) begin
            if (exp_test[i] == t) begin
                exp_q[exp_slot[i]].push_back(exp_rec[i]);
                n_exp++;
            end
        end
        cur_test  = t;
        test_busy = 1'b1;
        fork
            begin
                fork
                    drive_block(0, t);
                    drive_block(1, t);
                join
                while (pending() != 0) @(posedge clk);
                @(negedge clk);
                test_busy = 1'b0;
            end
            pace_ready(t);
        join
        $display("%s: %0d commits expected, %0d errors", test_name[t], n_exp, test_errors);
    endtask

    initial begin
        rst_n        = 1'b0;
        req_valid    = '0;
        req          = '0;
        commit_ready = '0;
        rng_state    = 32'h9847811a;
        errors       = 0;
        checks       = 0;
        commits_seen = 0;
        num_tests    = 0;
        num_reqs     = 0;
        num_exps     = 0;
        cur_test     = 0;
        test_busy    = 1'b0;
        load_trace();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        // A few idle cycles catch any stray commit after the last test
        repeat (10) @(posedge clk);
        $display("Summary: %0d tests, %0d commits, %0d checks, %0d errors, %0d assertion failures",
                 num_tests, commits_seen, checks, errors, i_exec_commit_top.i_props.fail_count);
        if (errors == 0 && i_exec_commit_top.i_props.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (200 * (num_reqs + num_exps + 1)) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 200 * (num_reqs + num_exps + 1));
        $display("test failed");
        $finish;
    end

endmodule

/* sim/exec_commit_trace.txt */
# TEST name random_stalls held_slot | REQ block uuid wid pid tmask op rd wb eop rs1[0] rs1[1] rs2[0] rs2[1]
# EXP slot uuid wid tmask(thread 3..0) rd wb eop data[0] data[1] data[2] data[3]
TEST alu_ops 0 -1
REQ 0 0001 0 0 11 ADD 1 1 1 00000005 7fffffff 00000003 00000001
EXP 0 0001 0 0011 1 1 1 00000008 80000000 00000000 00000000
REQ 1 0002 1 1 11 SUB 2 1 1 00000003 10000000 00000005 00000001
EXP 1 0002 1 1100 2 1 1 00000000 00000000 fffffffe 0fffffff
REQ 0 0003 2 1 11 AND 3 1 1 f0f0f0f0 12345678 ff00ff00 0000ffff
EXP 2 0003 2 1100 3 1 1 00000000 00000000 f000f000 00005678
REQ 1 0004 3 0 11 OR 4 1 1 0f0f0000 80000000 00f000f0 00000001
EXP 3 0004 3 0011 4 1 1 0fff00f0 80000001 00000000 00000000
REQ 0 0005 4 0 11 XOR 5 1 1 aaaaaaaa 12345678 55555555 12345678
EXP 0 0005 4 0011 5 1 1 ffffffff 00000000 00000000 00000000
REQ 1 0006 5 1 11 SLTU 6 1 1 80000000 00000001 00000001 ffffffff
EXP 1 0006 5 1100 6 1 1 00000000 00000000 00000000 00000001
TEST routing 1 -1
REQ 0 0100 0 0 01 ADD 10 1 0 00000000 00000001 00000010 00000010
EXP 0 0100 0 0001 10 1 0 00000010 00000000 00000000 00000000
REQ 1 0101 1 1 10 ADD 11 0 1 00001000 00001001 00000010 00000010
EXP 1 0101 1 1000 11 0 1 00000000 00000000 00000000 00001011
REQ 0 0102 2 0 11 ADD 12 1 1 00002000 00002001 00000010 00000010
EXP 2 0102 2 0011 12 1 1 00002010 00002011 00000000 00000000
REQ 1 0103 3 1 11 ADD 13 1 0 00003000 00003001 00000010 00000010
EXP 3 0103 3 1100 13 1 0 00000000 00000000 00003010 00003011
REQ 0 0104 4 1 10 ADD 14 0 0 00004000 00004001 00000010 00000010
EXP 0 0104 4 1000 14 0 0 00000000 00000000 00000000 00004011
REQ 1 0105 5 0 01 ADD 15 1 1 00005000 00005001 00000010 00000010
EXP 1 0105 5 0001 15 1 1 00005010 00000000 00000000 00000000
REQ 0 0106 6 1 11 ADD 16 1 1 00006000 00006001 00000010 00000010
EXP 2 0106 6 1100 16 1 1 00000000 00000000 00006010 00006011
REQ 1 0107 7 0 11 ADD 31 0 1 00007000 00007001 00000010 00000010
EXP 3 0107 7 0011 31 0 1 00007010 00007011 00000000 00000000
TEST widening 0 -1
REQ 0 0200 2 0 11 SUB 7 1 0 00000010 00000020 00000001 00000002
EXP 2 0200 2 0011 7 1 0 0000000f 0000001e 00000000 00000000
REQ 0 0200 2 1 01 SUB 7 1 1 00000030 00000040 00000003 00000004
EXP 2 0200 2 0100 7 1 1 00000000 00000000 0000002d 00000000
REQ 1 0201 3 0 10 XOR 8 1 0 0000ffff 0000ffff 000000ff 00ff0000
EXP 3 0201 3 0010 8 1 0 00000000 00ffffff 00000000 00000000
REQ 1 0201 3 1 11 XOR 8 1 1 11111111 22222222 11111111 00000000
EXP 3 0201 3 1100 8 1 1 00000000 00000000 00000000 22222222
TEST backpressure 1 2
REQ 0 0300 2 0 11 ADD 1 1 1 00000001 00000002 00000001 00000001
EXP 2 0300 2 0011 1 1 1 00000002 00000003 00000000 00000000
REQ 0 0301 6 1 11 ADD 2 1 1 00000003 00000004 00000001 00000001
EXP 2 0301 6 1100 2 1 1 00000000 00000000 00000004 00000005
REQ 1 0304 1 0 11 SLTU 5 1 1 fffffffe 00000002 ffffffff 00000002
EXP 1 0304 1 0011 5 1 1 00000001 00000000 00000000 00000000
REQ 0 0302 0 0 11 AND 3 1 0 ffffffff 0000000f 12345678 00000003
EXP 0 0302 0 0011 3 1 0 12345678 00000003 00000000 00000000
REQ 1 0305 3 1 01 SUB 6 0 1 00000000 00000000 00000001 00000000
EXP 3 0305 3 0100 6 0 1 00000000 00000000 ffffffff 00000000
REQ 0 0303 2 1 10 OR 4 1 1 00000000 00000100 00000000 00000022
EXP 2 0303 2 1000 4 1 1 00000000 00000000 00000000 00000122

/* tb.f */
+incdir+hdl
hdl/exec_pkg.sv
hdl/elastic_buffer.sv
hdl/alu_block.sv
hdl/gather_unit.sv
hdl/exec_commit_top.sv
sim/exec_commit_properties.sv
sim/exec_commit_tb.sv
